/* verilog/perf_macros.svh */
`ifndef PERF_MACROS_SVH
`define PERF_MACROS_SVH

// ----------------------------------------
// generator array
// ----------------------------------------
`define PERF_NUM_GEN 2

// ----------------------------------------
// bus widths
// ----------------------------------------
`define PERF_ADDR_W 20
`define PERF_DATA_W 16
`define PERF_STRB_W (`PERF_DATA_W / 8)
`define PERF_ID_W 4
// master id less the generator select bits
`define PERF_GEN_ID_W 3

// ----------------------------------------
// burst pattern
// ----------------------------------------
`define PERF_BURST_BEATS 4
`define PERF_NUM_BURSTS 4
`define PERF_STRIDE_BEATS 8

`define PERF_STAT_W 32

`endif

/* verilog/axi_wr_pkg.sv */
`include "perf_macros.svh"

package axi_wr_pkg;

  localparam logic [1:0] burst_incr = 2'b01;

  // address request as seen on the memory port
  typedef struct packed {
    logic [`PERF_ADDR_W-1:0] awaddr;
    logic [`PERF_ID_W-1:0]   awid;
    logic [7:0]              awlen;
    logic [2:0]              awsize;
    logic [1:0]              awburst;
  } aw_req_t;

  // same request before the arbiter adds the slot bits
  typedef struct packed {
    logic [`PERF_ADDR_W-1:0]   awaddr;
    logic [`PERF_GEN_ID_W-1:0] awid;
    logic [7:0]                awlen;
    logic [2:0]                awsize;
    logic [1:0]                awburst;
  } gen_aw_req_t;

  typedef struct packed {
    logic [`PERF_DATA_W-1:0] wdata;
    logic [`PERF_STRB_W-1:0] wstrb;
    logic                    wlast;
  } w_beat_t;

  typedef struct packed {
    logic [`PERF_ID_W-1:0] bid;
    logic [1:0]            bresp;
  } b_rsp_t;

  typedef struct packed {
    logic [`PERF_GEN_ID_W-1:0] bid;
    logic [1:0]                bresp;
  } gen_b_rsp_t;

endpackage

/* verilog/perf_pkg.sv */
package perf_pkg;

  // run sequencer states
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_wait_done,
    st_done
  } run_state_t;

  // counter readout select
  typedef enum logic [2:0] {
    sel_aw_count,
    sel_w_count,
    sel_b_count,
    sel_b_err_count,
    sel_run_cycles
  } stat_sel_t;

  localparam int num_stats = 5;

endpackage

/* verilog/perf_seq.sv */
`include "perf_macros.svh"

module perf_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  output logic [`PERF_NUM_GEN-1:0] gen_start,
  input  logic [`PERF_NUM_GEN-1:0] gen_busy,
  output logic                     run_active,
  output logic                     done
);
  import perf_pkg::*;

  run_state_t state;
  run_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      st_idle, st_done: begin
        if (start) begin
          state_next = st_run;
        end
      end
      // busy goes high on the edge that ends this cycle
      st_run: begin
        state_next = st_wait_done;
      end
      st_wait_done: begin
        if (gen_busy == '0) begin
          state_next = st_done;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      gen_start <= '0;
    end else begin
      state     <= state_next;
      gen_start <= {`PERF_NUM_GEN{state_next == st_run}};
    end
  end

  assign run_active = (state == st_run) || (state == st_wait_done);
  assign done       = (state == st_done);

  // generators answer the start pulse by going busy
  a_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
      (gen_start != '0) |=> (gen_busy == '1)
  );

endmodule

/* verilog/axi_perf_wr.sv */
`include "perf_macros.svh"

module axi_perf_wr #(
  parameter int gen_index = 0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  output logic                    busy,
  output logic                    awvalid,
  input  logic                    awready,
  output axi_wr_pkg::gen_aw_req_t aw,
  output logic                    wvalid,
  input  logic                    wready,
  output axi_wr_pkg::w_beat_t     w,
  input  logic                    bvalid,
  output logic                    bready,
  input  axi_wr_pkg::gen_b_rsp_t  b
);
  import axi_wr_pkg::*;

  localparam int addr_w       = `PERF_ADDR_W;
  localparam int data_w       = `PERF_DATA_W;
  localparam int gen_id_w     = `PERF_GEN_ID_W;
  localparam int beats        = `PERF_BURST_BEATS;
  localparam int num_bursts   = `PERF_NUM_BURSTS;
  localparam int stride_bytes = `PERF_STRIDE_BEATS * `PERF_STRB_W;
  localparam int cnt_w        = $clog2(num_bursts + 1);
  localparam int beat_w       = $clog2(beats + 1);
  // each generator owns a region of num_bursts strides
  localparam logic [addr_w-1:0] base_addr =
    addr_w'(gen_index * num_bursts * stride_bytes);

  logic [cnt_w-1:0]  aw_cnt;
  logic [cnt_w-1:0]  w_burst;
  logic [beat_w-1:0] w_beat;
  logic [cnt_w-1:0]  pending;
  logic              aw_fire;
  logic              w_fire;
  logic              b_fire;
  logic              last_b;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;
  assign last_b  = b_fire && (pending == cnt_w'(1)) && (aw_cnt == cnt_w'(num_bursts));

  // ----------------------------------------
  // address channel
  // ----------------------------------------
  assign awvalid = busy && (aw_cnt != cnt_w'(num_bursts));

  always_comb begin
    aw.awaddr  = base_addr + addr_w'(aw_cnt) * addr_w'(stride_bytes);
    aw.awid    = gen_id_w'(aw_cnt);
    aw.awlen   = 8'(beats - 1);
    aw.awsize  = 3'($clog2(`PERF_STRB_W));
    aw.awburst = burst_incr;
  end

  // ----------------------------------------
  // data channel, trails the address count
  // ----------------------------------------
  assign wvalid = busy && (w_burst != aw_cnt);

  always_comb begin
    w.wdata                 = '0;
    w.wdata[data_w-1 -: 8]  = 8'(gen_index);
    w.wdata[7:0]            = 8'(w_burst) * 8'(beats) + 8'(w_beat);
    w.wstrb                 = '1;
    w.wlast                 = (w_beat == beat_w'(beats - 1));
  end

  assign bready = busy;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      aw_cnt  <= '0;
      w_burst <= '0;
      w_beat  <= '0;
      pending <= '0;
    end else if (start && !busy) begin
      busy    <= 1'b1;
      aw_cnt  <= '0;
      w_burst <= '0;
      w_beat  <= '0;
      pending <= '0;
    end else begin
      if (aw_fire) begin
        aw_cnt <= aw_cnt + 1'b1;
      end
      if (w_fire) begin
        if (w.wlast) begin
          w_beat  <= '0;
          w_burst <= w_burst + 1'b1;
        end else begin
          w_beat <= w_beat + 1'b1;
        end
      end
      // bursts in flight
      if (aw_fire && !b_fire) begin
        pending <= pending + 1'b1;
      end else if (b_fire && !aw_fire) begin
        pending <= pending - 1'b1;
      end
      if (last_b) begin
        busy <= 1'b0;
      end
    end
  end

  a_aw_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      (awvalid && !awready) |=> (awvalid && $stable(aw))
  );

  // responses routed here belong to bursts this generator issued
  a_b_issued: assert property (
    @(posedge clk) disable iff (!rst_n)
      bvalid |-> ((cnt_w'(b.bid) < aw_cnt) && (pending != '0))
  );

endmodule

/* verilog/axi_wr_arbiter.sv */
`include "perf_macros.svh"

module axi_wr_arbiter (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                    [`PERF_NUM_GEN-1:0] awvalid,
  output logic                    [`PERF_NUM_GEN-1:0] awready,
  input  axi_wr_pkg::gen_aw_req_t [`PERF_NUM_GEN-1:0] aw,
  input  logic                    [`PERF_NUM_GEN-1:0] wvalid,
  output logic                    [`PERF_NUM_GEN-1:0] wready,
  input  axi_wr_pkg::w_beat_t     [`PERF_NUM_GEN-1:0] w,
  output logic                    [`PERF_NUM_GEN-1:0] bvalid,
  input  logic                    [`PERF_NUM_GEN-1:0] bready,
  output axi_wr_pkg::gen_b_rsp_t  [`PERF_NUM_GEN-1:0] b,
  output logic                                        m_awvalid,
  input  logic                                        m_awready,
  output axi_wr_pkg::aw_req_t                         m_aw,
  output logic                                        m_wvalid,
  input  logic                                        m_wready,
  output axi_wr_pkg::w_beat_t                         m_w,
  input  logic                                        m_bvalid,
  output logic                                        m_bready,
  input  axi_wr_pkg::b_rsp_t                          m_b
);
  import axi_wr_pkg::*;

  localparam int num_gen  = `PERF_NUM_GEN;
  localparam int gen_id_w = `PERF_GEN_ID_W;
  localparam int idx_w    = `PERF_ID_W - `PERF_GEN_ID_W;

  logic             grant_valid;
  logic [idx_w-1:0] grant_idx;
  logic             aw_done;
  logic [idx_w-1:0] rr_ptr;
  logic             pick_valid;
  logic [idx_w-1:0] pick_idx;
  logic             aw_phase;
  logic             w_phase;
  logic [idx_w-1:0] b_idx;

  // first requester at or after the pointer
  always_comb begin : rr_search
    int slot;
    pick_valid = 1'b0;
    pick_idx   = rr_ptr;
    for (int k = 0; k < num_gen; k++) begin
      slot = (int'(rr_ptr) + k) % num_gen;
      if (!pick_valid && awvalid[slot]) begin
        pick_valid = 1'b1;
        pick_idx   = idx_w'(slot);
      end
    end
  end

  assign aw_phase = grant_valid && !aw_done;
  assign w_phase  = grant_valid && aw_done;

  // ----------------------------------------
  // granted slot onto the master port
  // ----------------------------------------
  always_comb begin
    m_awvalid      = aw_phase && awvalid[grant_idx];
    m_aw.awaddr    = aw[grant_idx].awaddr;
    m_aw.awid      = {grant_idx, aw[grant_idx].awid};
    m_aw.awlen     = aw[grant_idx].awlen;
    m_aw.awsize    = aw[grant_idx].awsize;
    m_aw.awburst   = aw[grant_idx].awburst;
    m_wvalid       = w_phase && wvalid[grant_idx];
    m_w            = w[grant_idx];
    for (int i = 0; i < num_gen; i++) begin
      awready[i] = aw_phase && (grant_idx == idx_w'(i)) && m_awready;
      wready[i]  = w_phase && (grant_idx == idx_w'(i)) && m_wready;
    end
  end

  // ----------------------------------------
  // responses steered by the top id bits
  // ----------------------------------------
  assign b_idx    = m_b.bid[`PERF_ID_W-1 -: idx_w];
  assign m_bready = bready[b_idx];

  always_comb begin
    for (int i = 0; i < num_gen; i++) begin
      bvalid[i]   = m_bvalid && (b_idx == idx_w'(i));
      b[i].bid    = m_b.bid[gen_id_w-1:0];
      b[i].bresp  = m_b.bresp;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_valid <= 1'b0;
      grant_idx   <= '0;
      aw_done     <= 1'b0;
      rr_ptr      <= '0;
    end else if (!grant_valid) begin
      if (pick_valid) begin
        grant_valid <= 1'b1;
        grant_idx   <= pick_idx;
        aw_done     <= 1'b0;
      end
    end else if (m_awvalid && m_awready) begin
      aw_done <= 1'b1;
    end else if (m_wvalid && m_wready && m_w.wlast) begin
      // burst complete, next slot gets priority
      grant_valid <= 1'b0;
      rr_ptr      <= (grant_idx == idx_w'(num_gen - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

  // only the granted slot can have data waiting
  a_w_in_grant: assert property (
    @(posedge clk) disable iff (!rst_n)
      (wvalid != '0) |-> (w_phase && (wvalid == (num_gen'(1) << grant_idx)))
  );

endmodule

/* verilog/axi_wr_stats.sv */
`include "perf_macros.svh"

module axi_wr_stats (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    run_active,
  input  logic                    awvalid,
  input  logic                    awready,
  input  logic                    wvalid,
  input  logic                    wready,
  input  logic                    bvalid,
  input  logic                    bready,
  input  logic [1:0]              bresp,
  input  perf_pkg::stat_sel_t     stat_sel,
  output logic [`PERF_STAT_W-1:0] stat_val
);
  import perf_pkg::*;

  localparam int stat_w = `PERF_STAT_W;

  logic                 run_q;
  logic                 clear;
  logic [num_stats-1:0] hit;
  logic [stat_w-1:0]    counts [num_stats];

  // fresh run starts on the rising edge of run_active
  assign clear = run_active && !run_q;

  always_comb begin
    hit                  = '0;
    hit[sel_aw_count]    = awvalid && awready;
    hit[sel_w_count]     = wvalid && wready;
    hit[sel_b_count]     = bvalid && bready;
    hit[sel_b_err_count] = bvalid && bready && (bresp != 2'b00);
    hit[sel_run_cycles]  = run_active;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q <= 1'b0;
      for (int i = 0; i < num_stats; i++) begin
        counts[i] <= '0;
      end
    end else begin
      run_q <= run_active;
      for (int i = 0; i < num_stats; i++) begin
        if (clear) begin
          counts[i] <= stat_w'(hit[i]);
        end else begin
          counts[i] <= counts[i] + stat_w'(hit[i]);
        end
      end
    end
  end

  // unused select codes read as zero
  always_comb begin
    if (int'(stat_sel) < num_stats) begin
      stat_val = counts[stat_sel];
    end else begin
      stat_val = '0;
    end
  end

endmodule

/* verilog/axi_perf.sv */
`include "perf_macros.svh"

module axi_perf (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  output logic                    done,
  input  perf_pkg::stat_sel_t     stat_sel,
  output logic [`PERF_STAT_W-1:0] stat_val,
  output logic                    awvalid,
  output axi_wr_pkg::aw_req_t     aw,
  input  logic                    awready,
  output logic                    wvalid,
  output axi_wr_pkg::w_beat_t     w,
  input  logic                    wready,
  input  logic                    bvalid,
  input  axi_wr_pkg::b_rsp_t      b,
  output logic                    bready
);
  import axi_wr_pkg::*;

  localparam int num_gen = `PERF_NUM_GEN;

  logic [num_gen-1:0]              gen_start;
  logic [num_gen-1:0]              gen_busy;
  logic                            run_active;

  logic [num_gen-1:0]              gen_awvalid;
  logic [num_gen-1:0]              gen_awready;
  gen_aw_req_t [num_gen-1:0]       gen_aw;
  logic [num_gen-1:0]              gen_wvalid;
  logic [num_gen-1:0]              gen_wready;
  w_beat_t [num_gen-1:0]           gen_w;
  logic [num_gen-1:0]              gen_bvalid;
  logic [num_gen-1:0]              gen_bready;
  gen_b_rsp_t [num_gen-1:0]        gen_b;

  perf_seq perf_seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .gen_start (gen_start),
    .gen_busy  (gen_busy),
    .run_active(run_active),
    .done      (done)
  );

  for (genvar i = 0; i < num_gen; i++) begin : gen_perf_wr
    axi_perf_wr #(
      .gen_index(i)
    ) axi_perf_wr_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (gen_start[i]),
      .busy   (gen_busy[i]),
      .awvalid(gen_awvalid[i]),
      .awready(gen_awready[i]),
      .aw     (gen_aw[i]),
      .wvalid (gen_wvalid[i]),
      .wready (gen_wready[i]),
      .w      (gen_w[i]),
      .bvalid (gen_bvalid[i]),
      .bready (gen_bready[i]),
      .b      (gen_b[i])
    );
  end

  axi_wr_arbiter axi_wr_arbiter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .awvalid  (gen_awvalid),
    .awready  (gen_awready),
    .aw       (gen_aw),
    .wvalid   (gen_wvalid),
    .wready   (gen_wready),
    .w        (gen_w),
    .bvalid   (gen_bvalid),
    .bready   (gen_bready),
    .b        (gen_b),
    .m_awvalid(awvalid),
    .m_awready(awready),
    .m_aw     (aw),
    .m_wvalid (wvalid),
    .m_wready (wready),
    .m_w      (w),
    .m_bvalid (bvalid),
    .m_bready (bready),
    .m_b      (b)
  );

  // observes the master port only
  axi_wr_stats axi_wr_stats_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run_active(run_active),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready),
    .bresp     (b.bresp),
    .stat_sel  (stat_sel),
    .stat_val  (stat_val)
  );

endmodule

/* bench/axi_wr_responder.sv */
`include "perf_macros.svh"

module axi_wr_responder (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [7:0]                               aw_stall_pct,
  input  logic [7:0]                               w_stall_pct,
  input  logic [7:0]                               b_delay_max,
  input  logic [`PERF_NUM_GEN*`PERF_NUM_BURSTS-1:0] err_mask,
  input  logic                                     awvalid,
  input  axi_wr_pkg::aw_req_t                      aw,
  output logic                                     awready,
  input  logic                                     wvalid,
  input  axi_wr_pkg::w_beat_t                      w,
  output logic                                     wready,
  output logic                                     bvalid,
  output axi_wr_pkg::b_rsp_t                       b,
  input  logic                                     bready
);
  timeunit 1ns;
  timeprecision 100ps;
  import axi_wr_pkg::*;

  localparam int gen_id_w = `PERF_GEN_ID_W;
  localparam int idx_w    = `PERF_ID_W - `PERF_GEN_ID_W;

  logic [31:0]           lfsr = 32'h52e8_79d6;
  logic                  awready_q = 1'b0;
  logic                  wready_q = 1'b0;
  logic                  bvalid_q = 1'b0;
  b_rsp_t                b_r = '0;
  logic [`PERF_ID_W-1:0] addr_ids [$];
  logic [`PERF_ID_W-1:0] resp_ids [$];
  int                    b_wait = 0;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  always @(posedge clk) begin
    int                    r;
    int                    burst;
    logic [`PERF_ID_W-1:0] id;
    if (!rst_n) begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      b_r       <= '0;
      addr_ids.delete();
      resp_ids.delete();
      b_wait = 0;
    end else begin
      if (awvalid && awready_q) begin
        addr_ids.push_back(aw.awid);
      end
      // burst complete once its last beat is in
      if (wvalid && wready_q && w.wlast && (addr_ids.size() > 0)) begin
        resp_ids.push_back(addr_ids.pop_front());
      end
      if (bvalid_q && bready) begin
        bvalid_q <= 1'b0;
        take_bits(4, r);
        b_wait = r % (int'(b_delay_max) + 1);
      end else if (!bvalid_q && (resp_ids.size() > 0)) begin
        if (b_wait > 0) begin
          b_wait = b_wait - 1;
        end else begin
          id = resp_ids.pop_front();
          burst = int'(id[`PERF_ID_W-1 -: idx_w]) * `PERF_NUM_BURSTS + int'(id[gen_id_w-1:0]);
          bvalid_q  <= 1'b1;
          b_r.bid   <= id;
          b_r.bresp <= err_mask[burst] ? 2'b10 : 2'b00;
        end
      end
      take_bits(7, r);
      awready_q <= (r * 100) >= (int'(aw_stall_pct) * 128);
      take_bits(7, r);
      wready_q <= (r * 100) >= (int'(w_stall_pct) * 128);
    end
  end

  assign awready = awready_q;
  assign wready  = wready_q;
  assign bvalid  = bvalid_q;
  assign b       = b_r;

endmodule

/* bench/tb_axi_perf.sv */
`include "perf_macros.svh"

module tb_axi_perf;
  timeunit 1ns;
  timeprecision 100ps;
  import axi_wr_pkg::*;
  import perf_pkg::*;

  localparam int clk_period   = 40;
  localparam int num_tests    = 5;
  localparam int trace_cols   = 5;
  localparam int num_gen      = `PERF_NUM_GEN;
  localparam int nb           = `PERF_NUM_BURSTS;
  localparam int beats        = `PERF_BURST_BEATS;
  localparam int byte_w       = `PERF_DATA_W / 8;
  localparam int stride_bytes = `PERF_STRIDE_BEATS * byte_w;
  localparam int total_bursts = num_gen * nb;
  localparam int total_beats  = total_bursts * beats;
  // cycles per beat, stalls and response delay included
  localparam int stall_bound  = 40;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    start;
  logic                    done;
  stat_sel_t               stat_sel;
  logic [`PERF_STAT_W-1:0] stat_val;
  logic                    awvalid;
  aw_req_t                 aw;
  logic                    awready;
  logic                    wvalid;
  w_beat_t                 w;
  logic                    wready;
  logic                    bvalid;
  b_rsp_t                  b;
  logic                    bready;
  logic [7:0]              aw_stall_pct;
  logic [7:0]              w_stall_pct;
  logic [7:0]              b_delay_max;
  logic [total_bursts-1:0] err_mask;
  logic [7:0]              trace_mem [num_tests * trace_cols];

  int   mon_errors = 0;
  int   seq_errors = 0;
  int   failed_tests = 0;
  bit   seen [total_bursts];
  int   wq [$];
  int   beat = 0;
  int   b_fires = 0;
  bit   started = 1'b0;
  logic done_q = 1'b0;
  logic start_q = 1'b0;

  axi_perf axi_perf_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .done    (done),
    .stat_sel(stat_sel),
    .stat_val(stat_val),
    .awvalid (awvalid),
    .aw      (aw),
    .awready (awready),
    .wvalid  (wvalid),
    .w       (w),
    .wready  (wready),
    .bvalid  (bvalid),
    .b       (b),
    .bready  (bready)
  );

  axi_wr_responder axi_wr_responder_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .aw_stall_pct(aw_stall_pct),
    .w_stall_pct (w_stall_pct),
    .b_delay_max (b_delay_max),
    .err_mask    (err_mask),
    .awvalid     (awvalid),
    .aw          (aw),
    .awready     (awready),
    .wvalid      (wvalid),
    .w           (w),
    .wready      (wready),
    .bvalid      (bvalid),
    .b           (b),
    .bready      (bready)
  );

  always #(clk_period / 2) clk = ~clk;

  initial begin
    #((num_tests * total_beats * stall_bound + 20) * clk_period);
    $display("watchdog expired before the last test finished");
    $display("sim failed");
    $finish;
  end

  // ----------------------------------------
  // master port monitor
  // ----------------------------------------
  task automatic check_aw(input aw_req_t a);
    int                     g;
    int                     k;
    bit                     fresh;
    logic [`PERF_ADDR_W-1:0] exp_addr;
    g = int'(a.awid[`PERF_ID_W-1:`PERF_GEN_ID_W]);
    k = int'(a.awid[`PERF_GEN_ID_W-1:0]);
    fresh = (g < num_gen) && (k < nb);
    if (fresh) begin
      fresh = !seen[g * nb + k];
    end
    assert (fresh) else begin
      $display("AW id 0x%0h does not name a new burst", a.awid);
      mon_errors++;
    end
    exp_addr = `PERF_ADDR_W'(g * nb * stride_bytes + k * stride_bytes);
    assert (a.awaddr == exp_addr) else begin
      $display("ERR awaddr: got 0x%0h expected 0x%0h", a.awaddr, exp_addr);
      mon_errors++;
    end
    assert (a.awlen == 8'(beats - 1)) else begin
      $display("ERR awlen: got 0x%0h expected 0x%0h", a.awlen, 8'(beats - 1));
      mon_errors++;
    end
    assert (a.awsize == 3'($clog2(byte_w))) else begin
      $display("ERR awsize: got 0x%0h expected 0x%0h", a.awsize, 3'($clog2(byte_w)));
      mon_errors++;
    end
    assert (a.awburst == 2'b01) else begin
      $display("ERR awburst: got 0x%0h expected 0x1", a.awburst);
      mon_errors++;
    end
    if ((g < num_gen) && (k < nb)) begin
      seen[g * nb + k] = 1'b1;
    end
    wq.push_back(g * nb + k);
  endtask

  task automatic check_w(input w_beat_t d);
    int                      g;
    int                      k;
    logic [`PERF_DATA_W-1:0] exp_data;
    assert (wq.size() > 0) else begin
      $display("W beat arrived with no address in flight");
      mon_errors++;
    end
    if (wq.size() > 0) begin
      g = wq[0] / nb;
      k = wq[0] % nb;
      exp_data = '0;
      exp_data[`PERF_DATA_W-1 -: 8] = 8'(g);
      exp_data[7:0] = 8'(k * beats + beat);
      assert (d.wdata == exp_data) else begin
        $display("ERR wdata: got 0x%0h expected 0x%0h", d.wdata, exp_data);
        mon_errors++;
      end
      assert (d.wstrb == '1) else begin
        $display("ERR wstrb: got 0x%0h expected 0x%0h", d.wstrb, {`PERF_STRB_W{1'b1}});
        mon_errors++;
      end
      assert (d.wlast == (beat == beats - 1)) else begin
        $display("ERR wlast: got 0x%0h expected 0x%0h", d.wlast, beat == beats - 1);
        mon_errors++;
      end
      if (beat == beats - 1) begin
        beat = 0;
        void'(wq.pop_front());
      end else begin
        beat++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (start) begin
        for (int i = 0; i < total_bursts; i++) begin
          seen[i] = 1'b0;
        end
        wq.delete();
        beat = 0;
        b_fires = 0;
        started = 1'b1;
      end
      if (done || !started) begin
        assert (!awvalid && !wvalid && !bready) else begin
          $display("write traffic or bready while the DUT is idle");
          mon_errors++;
        end
      end
      if (done_q && !done) begin
        assert (start_q) else begin
          $display("done fell without a new start");
          mon_errors++;
        end
      end
      if (done && !done_q) begin
        assert (b_fires == total_bursts) else begin
          $display("done rose after %0d of %0d write responses", b_fires, total_bursts);
          mon_errors++;
        end
      end
      if (awvalid && awready) begin
        check_aw(aw);
      end
      if (wvalid && wready) begin
        check_w(w);
      end
      if (bvalid && bready) begin
        b_fires++;
      end
    end
    done_q = done;
    start_q = start;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  task automatic read_stat(input stat_sel_t sel, output logic [`PERF_STAT_W-1:0] val);
    stat_sel <= sel;
    @(posedge clk);
    val = stat_val;
  endtask

  task automatic check_count(input stat_sel_t sel, input string name, input int expected);
    logic [`PERF_STAT_W-1:0] val;
    read_stat(sel, val);
    assert (val == `PERF_STAT_W'(expected)) else begin
      $display("ERR %s: got 0x%0h expected 0x%0h", name, val, expected);
      seq_errors++;
    end
  endtask

  task automatic run_test(input int t);
    int                      base;
    int                      errs_before;
    logic [`PERF_STAT_W-1:0] cycles;
    base = t * trace_cols;
    errs_before = mon_errors + seq_errors;
    aw_stall_pct <= trace_mem[base];
    w_stall_pct  <= trace_mem[base + 1];
    b_delay_max  <= trace_mem[base + 2];
    err_mask     <= trace_mem[base + 3];
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(posedge clk);
    end while (!done);
    assert ((wq.size() == 0) && (beat == 0)) else begin
      $display("run ended with %0d bursts missing data", wq.size());
      seq_errors++;
    end
    check_count(sel_aw_count, "aw_count", total_bursts);
    check_count(sel_w_count, "w_count", total_beats);
    check_count(sel_b_count, "b_count", total_bursts);
    check_count(sel_b_err_count, "b_err_count", int'(trace_mem[base + 4]));
    read_stat(sel_run_cycles, cycles);
    assert (cycles >= `PERF_STAT_W'(total_beats)) else begin
      $display("ERR run_cycles: got 0x%0h expected at least 0x%0h", cycles, total_beats);
      seq_errors++;
    end
    if (mon_errors + seq_errors == errs_before) begin
      $display("test %0d aw stall %0d%% w stall %0d%% b delay %0d: ok", t,
               trace_mem[base], trace_mem[base + 1], trace_mem[base + 2]);
    end else begin
      failed_tests++;
      $display("test %0d aw stall %0d%% w stall %0d%% b delay %0d: FAIL", t,
               trace_mem[base], trace_mem[base + 1], trace_mem[base + 2]);
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    start        = 1'b0;
    stat_sel     = sel_aw_count;
    aw_stall_pct = 8'd0;
    w_stall_pct  = 8'd0;
    b_delay_max  = 8'd0;
    err_mask     = '0;
    $readmemh("bench/perf_trace.txt", trace_mem);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests,
             mon_errors + seq_errors);
    if ((mon_errors + seq_errors) == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* bench/perf_trace.txt */
// columns: awready stall %, wready stall %, b delay max, slverr mask, expected b_err_count
// all hex; mask bit n is burst n mod 4 of generator n / 4
00 00 00 00 00
19 0a 03 05 02
32 32 08 81 02
0a 4b 0f ff 08
46 1e 05 3c 04

/* tb.f */
+incdir+verilog
verilog/axi_wr_pkg.sv
verilog/perf_pkg.sv
verilog/perf_seq.sv
verilog/axi_perf_wr.sv
verilog/axi_wr_arbiter.sv
verilog/axi_wr_stats.sv
verilog/axi_perf.sv
bench/axi_wr_responder.sv
bench/tb_axi_perf.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_axi_perf
LINT_TOP  ?= axi_perf
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= sim passed

EXE  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(EXE): $(SRCS) $(wildcard verilog/*.svh) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(EXE)
	@out="$$($(EXE))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
